// ==== pep9Cpu.f ====
src/pep9Pkg.sv
src/memReader.sv
src/instrDecoder.sv
src/pep9Alu.sv
src/regFile.sv
src/cpuSequencer.sv
src/pep9Cpu.sv
tb/pep9Cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f pep9Cpu.f --top-module pep9Cpu_tb -o pep9CpuSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

output=$(./obj_dir/pep9CpuSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== src/cpuSequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Phase sequencer, one instruction in flight at a time
// PC steps after every byte fetched; unary skips the operand spec
// Halts for good on STOP or any illegal specifier
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpuSequencer import pep9Pkg::*;
(
    input  logic    Sysclk,
    input  logic    resetbar,
    output logic    readStart,
    output addrT    readAddr,
    input  logic    readDone,
    input  byteT    readData,
    output byteT    spec,
    input  decodedT decoded,
    input  byteT    regA,
    input  byteT    regX,
    input  byteT    aluResult,
    input  flagsT   aluFlags,
    output byteT    operand,
    output byteT    regValue,
    output logic    wrEn,
    output retireT  retire,
    output logic    halted
);

    seqStateT state;
    addrT     pc;
    byteT     specReg;
    addrT     osReg;         // Operand specifier
    byteT     operandReg;    // Byte read in direct mode
    logic     issued;        // Read already started in this state
    logic     readPhase;

    assign readPhase = (state == fetchSpec) || (state == fetchOsHi) ||
                       (state == fetchOsLo) || (state == readOperand);
    assign readStart = readPhase && !issued;
    assign readAddr  = (state == readOperand) ? osReg : pc;

    // Decode straight off the returning byte during fetch
    assign spec = (state == fetchSpec) ? readData : specReg;

    assign operand  = (decoded.mode == direct) ? operandReg : osReg[7:0];
    assign regValue = (decoded.dest == pep9Pkg::regX) ? regX : regA;

    assign wrEn   = (state == execute);
    assign retire = '{valid: wrEn, dest: decoded.dest, value: aluResult, flags: aluFlags};
    assign halted = (state == pep9Pkg::halted);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state  <= fetchSpec;
            pc     <= resetPc;
            issued <= 1'b0;
        end
        else
        begin
            if (readStart)
                issued <= 1'b1;
            if (readDone)
                issued <= 1'b0;

            case (state)
                fetchSpec:
                    if (readDone)
                    begin
                        pc <= pc + 16'd1;
                        if (!decoded.legal)
                            state <= pep9Pkg::halted;
                        else if (decoded.unary)
                            state <= execute;
                        else
                            state <= fetchOsHi;
                    end
                fetchOsHi:
                    if (readDone)
                    begin
                        pc    <= pc + 16'd1;
                        state <= fetchOsLo;
                    end
                fetchOsLo:
                    if (readDone)
                    begin
                        pc    <= pc + 16'd1;
                        state <= (decoded.mode == direct) ? readOperand : execute;
                    end
                readOperand:
                    if (readDone)
                        state <= execute;
                execute: state <= fetchSpec;    // Write-back and retire
                default: state <= pep9Pkg::halted;
            endcase
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (readDone)
        begin
            case (state)
                fetchSpec:   specReg     <= readData;
                fetchOsHi:   osReg[15:8] <= readData;
                fetchOsLo:   osReg[7:0]  <= readData;
                readOperand: operandReg  <= readData;
                default:     ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/instrDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational decode of one instruction specifier
// STOP, unknown opcodes and modes other than 0 or 1 are not legal
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import pep9Pkg::*;
(
    input  byteT    spec,
    output decodedT decoded
);

    byteT unaryBase;    // Specifier with r cleared

    assign unaryBase = {spec[7:1], 1'b0};

    always_comb
    begin
        decoded.unary = 1'b0;
        decoded.legal = 1'b0;
        decoded.op    = pass;
        decoded.dest  = regNone;
        decoded.mode  = immediate;

        if (spec == opStop)
        begin
            decoded.legal = 1'b0;    // Halt request
        end
        else if (spec[7:4] < opAddHi)
        begin
            decoded.unary = 1'b1;
            decoded.legal = 1'b1;
            case (unaryBase)
                opNotBase: decoded.op = notOp;
                opNegBase: decoded.op = neg;
                opAslBase: decoded.op = asl;
                opAsrBase: decoded.op = asr;
                opRolBase: decoded.op = rol;
                opRorBase: decoded.op = ror;
                default:   decoded.legal = 1'b0;
            endcase
            if (decoded.legal)
                decoded.dest = spec[0] ? regX : regA;
        end
        else
        begin
            decoded.legal = (spec[2:0] == 3'd0) || (spec[2:0] == 3'd1);
            case (spec[7:4])
                opAddHi: decoded.op = add;
                opSubHi: decoded.op = sub;
                opAndHi: decoded.op = andOp;
                opOrHi:  decoded.op = orOp;
                opLdbHi: decoded.op = pass;    // Load passes the operand
                default: decoded.legal = 1'b0;
            endcase
            decoded.mode = spec[0] ? direct : immediate;
            if (decoded.legal)
                decoded.dest = spec[3] ? regX : regA;
        end
    end

endmodule

`default_nettype wire

// ==== src/memReader.sv ====
//////////////////////////////////////////////////////////////////////
// One-byte read master on a four-phase req/ack port
// A start seen while the previous ack is still high is held
// until ack falls; readDone is a one-cycle pulse
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memReader import pep9Pkg::*;
(
    input  logic   Sysclk,
    input  logic   resetbar,
    input  logic   readStart,
    input  addrT   readAddr,
    output logic   readDone,
    output byteT   readData,
    output memReqT memReq,
    input  logic   memAck,
    input  byteT   memData
);

    typedef enum logic [1:0] {rdIdle, rdRequest, rdRelease} rdStateT;

    rdStateT state;
    logic    reqReg;
    logic    pending;    // Start arrived during release
    addrT    addrReg;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state    <= rdIdle;
            reqReg   <= 1'b0;
            pending  <= 1'b0;
            readDone <= 1'b0;
        end
        else
        begin
            readDone <= 1'b0;
            case (state)
                rdIdle:
                    if (readStart)
                    begin
                        reqReg <= 1'b1;
                        state  <= rdRequest;
                    end
                rdRequest:
                    if (memAck)    // Data valid with ack
                    begin
                        reqReg   <= 1'b0;
                        readDone <= 1'b1;
                        state    <= rdRelease;
                    end
                default:
                begin
                    if (readStart)
                        pending <= 1'b1;
                    // Memory must drop ack before the next req
                    if (!memAck)
                    begin
                        if (pending || readStart)
                        begin
                            reqReg  <= 1'b1;
                            pending <= 1'b0;
                            state   <= rdRequest;
                        end
                        else
                            state <= rdIdle;
                    end
                end
            endcase
        end
    end

    // Address held steady while req is high
    always_ff @(posedge Sysclk)
    begin
        if (readStart && state != rdRequest)
            addrReg <= readAddr;
        if (state == rdRequest && memAck)
            readData <= memData;
    end

    assign memReq = '{req: reqReg, addr: addrReg};

endmodule

`default_nettype wire

// ==== src/pep9Alu.sv ====
//////////////////////////////////////////////////////////////////////
// Byte ALU with NZVC status
// Flags an operation does not define keep their incoming value
// ROL and ROR rotate through the incoming carry
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pep9Alu import pep9Pkg::*;
(
    input  aluOpT op,
    input  byteT  regValue,
    input  byteT  operand,
    input  flagsT flagsIn,
    output byteT  result,
    output flagsT flagsOut
);

    byteT       addend;
    logic [8:0] sum;       // Carry out in bit 8
    logic       updNz;

    // SUB is reg + ~operand + 1
    assign addend = (op == sub) ? ~operand : operand;
    assign sum    = {1'b0, regValue} + {1'b0, addend} + {8'd0, op == sub};

    always_comb
    begin
        result   = regValue;
        flagsOut = flagsIn;
        updNz    = 1'b1;

        case (op)
            add, sub:
            begin
                result     = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = (regValue[7] == addend[7]) && (sum[7] != regValue[7]);
            end
            andOp: result = regValue & operand;
            orOp:  result = regValue | operand;
            pass:  result = operand;
            notOp: result = ~regValue;
            neg:
            begin
                result     = -regValue;
                flagsOut.v = (regValue == 8'h80);    // Only -128 overflows
            end
            asl:
            begin
                result     = {regValue[6:0], 1'b0};
                flagsOut.c = regValue[7];
                flagsOut.v = regValue[7] ^ regValue[6];
            end
            asr:
            begin
                result     = {regValue[7], regValue[7:1]};
                flagsOut.c = regValue[0];
            end
            rol:
            begin
                result     = {regValue[6:0], flagsIn.c};
                flagsOut.c = regValue[7];
                updNz      = 1'b0;
            end
            ror:
            begin
                result     = {flagsIn.c, regValue[7:1]};
                flagsOut.c = regValue[0];
                updNz      = 1'b0;
            end
            default: updNz = 1'b0;
        endcase

        if (updNz)
        begin
            flagsOut.n = result[7];
            flagsOut.z = (result == 8'h00);
        end
    end

endmodule

`default_nettype wire

// ==== src/pep9Cpu.sv ====
//////////////////////////////////////////////////////////////////////
// Pep/9 subset processor, top level
// Single memory read port with four-phase req/ack
// retire.valid pulses once per completed instruction
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pep9Cpu import pep9Pkg::*;
(
    input  logic   Sysclk,
    input  logic   resetbar,
    output memReqT memReq,
    input  logic   memAck,
    input  byteT   memData,
    output retireT retire,
    output logic   halted
);

    logic    readStart;
    addrT    readAddr;
    logic    readDone;
    byteT    readData;
    byteT    spec;
    decodedT decoded;
    byteT    aValue;
    byteT    xValue;
    flagsT   flags;
    byteT    aluResult;
    flagsT   aluFlags;
    byteT    operand;
    byteT    regValue;
    logic    wrEn;

    memReader reader_i (
        .Sysclk   (Sysclk),
        .resetbar (resetbar),
        .readStart(readStart),
        .readAddr (readAddr),
        .readDone (readDone),
        .readData (readData),
        .memReq   (memReq),
        .memAck   (memAck),
        .memData  (memData)
    );

    instrDecoder decoder_i (
        .spec   (spec),
        .decoded(decoded)
    );

    pep9Alu alu_i (
        .op      (decoded.op),
        .regValue(regValue),
        .operand (operand),
        .flagsIn (flags),
        .result  (aluResult),
        .flagsOut(aluFlags)
    );

    regFile regs_i (
        .Sysclk  (Sysclk),
        .resetbar(resetbar),
        .wrEn    (wrEn),
        .wrSel   (decoded.dest),
        .wrValue (aluResult),
        .wrFlags (aluFlags),
        .regA    (aValue),
        .regX    (xValue),
        .flags   (flags)
    );

    cpuSequencer seq_i (
        .Sysclk   (Sysclk),
        .resetbar (resetbar),
        .readStart(readStart),
        .readAddr (readAddr),
        .readDone (readDone),
        .readData (readData),
        .spec     (spec),
        .decoded  (decoded),
        .regA     (aValue),
        .regX     (xValue),
        .aluResult(aluResult),
        .aluFlags (aluFlags),
        .operand  (operand),
        .regValue (regValue),
        .wrEn     (wrEn),
        .retire   (retire),
        .halted   (halted)
    );

endmodule

`default_nettype wire

// ==== src/pep9Pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and opcodes for the 8-bit Pep/9 subset processor
// A and X are byte wide; no word or SP operations
// Only modes 0 (immediate) and 1 (direct) are supported
//////////////////////////////////////////////////////////////////////
`default_nettype none

package pep9Pkg;

    typedef logic [7:0]  byteT;    // Data byte
    typedef logic [15:0] addrT;    // Memory address

    // Write target of an instruction
    typedef enum logic [1:0] {regA, regX, regNone} regSelT;

    typedef enum logic [3:0] {
        add, sub, andOp, orOp, pass, notOp, neg, asl, asr, rol, ror
    } aluOpT;

    typedef enum logic {immediate, direct} addrModeT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flagsT;

    typedef struct packed {
        logic     unary;
        logic     legal;
        aluOpT    op;
        regSelT   dest;
        addrModeT mode;
    } decodedT;

    typedef struct packed {
        logic req;
        addrT addr;
    } memReqT;

    typedef struct packed {
        logic   valid;
        regSelT dest;
        byteT   value;
        flagsT  flags;
    } retireT;

    typedef enum logic [2:0] {
        fetchSpec, fetchOsHi, fetchOsLo, readOperand, execute, halted
    } seqStateT;

    // Unary opcodes, bit 0 is r
    localparam byteT opNotBase = 8'h18;
    localparam byteT opNegBase = 8'h1A;
    localparam byteT opAslBase = 8'h1C;
    localparam byteT opAsrBase = 8'h1E;
    localparam byteT opRolBase = 8'h20;
    localparam byteT opRorBase = 8'h22;

    // Non-unary opcodes, specifier bits 7..4
    localparam logic [3:0] opAddHi = 4'd6;
    localparam logic [3:0] opSubHi = 4'd7;
    localparam logic [3:0] opAndHi = 4'd8;
    localparam logic [3:0] opOrHi  = 4'd9;
    localparam logic [3:0] opLdbHi = 4'd13;

    localparam byteT opStop  = 8'h00;
    localparam addrT resetPc = 16'h0000;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
//////////////////////////////////////////////////////////////////////
// Byte registers A and X plus NZVC
// One write port; flags are written with every register write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module regFile import pep9Pkg::*;
(
    input  logic   Sysclk,
    input  logic   resetbar,
    input  logic   wrEn,
    input  regSelT wrSel,
    input  byteT   wrValue,
    input  flagsT  wrFlags,
    output byteT   regA,
    output byteT   regX,
    output flagsT  flags
);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            regA  <= 8'h00;
            regX  <= 8'h00;
            flags <= '0;
        end
        else if (wrEn)
        begin
            case (wrSel)
                pep9Pkg::regA: regA <= wrValue;
                pep9Pkg::regX: regX <= wrValue;
                default:       ;    // Flags only
            endcase
            flags <= wrFlags;
        end
    end

endmodule

`default_nettype wire

// ==== tb/pep9Cpu_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the Pep/9 subset processor
// Memory model holds 256 bytes and decodes only address bits 7..0
// Ack delay of 0 to 3 cycles from an xorshift generator, seed 25
// Expected results are hand-worked for the program table below
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pep9Cpu_tb import pep9Pkg::*;
();

    localparam int numRows    = 29;
    localparam int cycleLimit = numRows * 40 + 50;

    typedef enum logic [1:0] {unaryInstr, immInstr, dirInstr} instrKindT;

    logic   Sysclk   = 1'b0;
    logic   resetbar = 1'b0;
    memReqT memReq;
    logic   memAck   = 1'b0;
    byteT   memData  = 8'h00;
    retireT retire;
    logic   cpuHalted;

    byteT mem [256];

    // Program table, one row per instruction
    string     rowName  [numRows];
    byteT      rowSpec  [numRows];
    addrT      rowOs    [numRows];
    byteT      rowData  [numRows];    // Byte at the operand address, direct mode only
    instrKindT rowKind  [numRows];
    regSelT    rowDest  [numRows];
    byteT      rowValue [numRows];
    flagsT     rowFlags [numRows];
    int        rowCount = 0;

    addrT        reqAddrs [$];    // Every request address seen, in order
    addrT        expAddrs [$];
    int          violations  = 0;
    logic        prevReq     = 1'b0;
    addrT        prevAddr    = '0;
    logic [1:0]  waitCycles  = '0;
    logic [31:0] rngState    = 32'd25;
    int          cycles      = 0;
    int          errorCount  = 0;
    int          testCount   = 0;
    int          failCount   = 0;
    int          retireCount = 0;

    always #5 Sysclk = ~Sysclk;

    pep9Cpu dut_i (
        .Sysclk  (Sysclk),
        .resetbar(resetbar),
        .memReq  (memReq),
        .memAck  (memAck),
        .memData (memData),
        .retire  (retire),
        .halted  (cpuHalted)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compareValue(input string testName, input string field,
                                input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s %s: expected %h, actual %h", testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string testName, input int errBefore);
        testCount++;
        if (errorCount != errBefore)
            failCount++;
        $display("Test %s finished with %0d errors", testName, errorCount - errBefore);
    endtask

    task automatic addRow(input string name, input byteT spec, input addrT os,
                          input byteT data, input instrKindT kind, input regSelT dest,
                          input byteT value, input flagsT flags);
        rowName[rowCount]  = name;
        rowSpec[rowCount]  = spec;
        rowOs[rowCount]    = os;
        rowData[rowCount]  = data;
        rowKind[rowCount]  = kind;
        rowDest[rowCount]  = dest;
        rowValue[rowCount] = value;
        rowFlags[rowCount] = flags;
        rowCount++;
    endtask

    // Flags are nzvc; rows 0..26 run as one program, 27..28 after a second reset
    task automatic buildTable();
        addRow("ldba imm 7f", 8'hD0, 16'h007F, 8'h00, immInstr, regA, 8'h7F, 4'b0000);
        addRow("adda overflow", 8'h60, 16'h0001, 8'h00, immInstr, regA, 8'h80, 4'b1010);
        addRow("adda carry zero", 8'h60, 16'h0080, 8'h00, immInstr, regA, 8'h00, 4'b0111);
        addRow("ldbx imm 05", 8'hD8, 16'h0005, 8'h00, immInstr, regX, 8'h05, 4'b0011);
        addRow("subx borrow", 8'h78, 16'h0007, 8'h00, immInstr, regX, 8'hFE, 4'b1000);
        addRow("subx zero carry", 8'h78, 16'h00FE, 8'h00, immInstr, regX, 8'h00, 4'b0101);
        addRow("suba negative", 8'h70, 16'h0001, 8'h00, immInstr, regA, 8'hFF, 4'b1000);
        addRow("ldba imm 80", 8'hD0, 16'h0080, 8'h00, immInstr, regA, 8'h80, 4'b1000);
        addRow("suba overflow", 8'h70, 16'h0001, 8'h00, immInstr, regA, 8'h7F, 4'b0011);
        addRow("anda imm 0f", 8'h80, 16'h000F, 8'h00, immInstr, regA, 8'h0F, 4'b0011);
        addRow("andx zero", 8'h88, 16'h0000, 8'h00, immInstr, regX, 8'h00, 4'b0111);
        addRow("orx negative", 8'h98, 16'h0090, 8'h00, immInstr, regX, 8'h90, 4'b1011);
        addRow("ora imm 30", 8'h90, 16'h0030, 8'h00, immInstr, regA, 8'h3F, 4'b0011);
        addRow("ldba direct", 8'hD1, 16'h00C0, 8'hC4, dirInstr, regA, 8'hC4, 4'b1011);
        addRow("adda direct", 8'h61, 16'h00C1, 8'h3C, dirInstr, regA, 8'h00, 4'b0101);
        addRow("ldbx imm 5a", 8'hD8, 16'h005A, 8'h00, immInstr, regX, 8'h5A, 4'b0001);
        addRow("notx", 8'h19, 16'h0000, 8'h00, unaryInstr, regX, 8'hA5, 4'b1001);
        addRow("ldba imm 80 again", 8'hD0, 16'h0080, 8'h00, immInstr, regA, 8'h80, 4'b1001);
        addRow("nega overflow", 8'h1A, 16'h0000, 8'h00, unaryInstr, regA, 8'h80, 4'b1011);
        addRow("asla carry", 8'h1C, 16'h0000, 8'h00, unaryInstr, regA, 8'h00, 4'b0111);
        addRow("negx", 8'h1B, 16'h0000, 8'h00, unaryInstr, regX, 8'h5B, 4'b0001);
        addRow("asrx positive", 8'h1F, 16'h0000, 8'h00, unaryInstr, regX, 8'h2D, 4'b0001);
        addRow("rorx carry in", 8'h23, 16'h0000, 8'h00, unaryInstr, regX, 8'h96, 4'b0001);
        addRow("rola carry in", 8'h20, 16'h0000, 8'h00, unaryInstr, regA, 8'h01, 4'b0000);
        addRow("asrx negative", 8'h1F, 16'h0000, 8'h00, unaryInstr, regX, 8'hCB, 4'b1000);
        addRow("rolx", 8'h21, 16'h0000, 8'h00, unaryInstr, regX, 8'h96, 4'b1001);
        addRow("nota", 8'h18, 16'h0000, 8'h00, unaryInstr, regA, 8'hFE, 4'b1001);
        addRow("ldbx after reset", 8'hD8, 16'h0042, 8'h00, immInstr, regX, 8'h42, 4'b0000);
        addRow("addx overflow", 8'h68, 16'h0042, 8'h00, immInstr, regX, 8'h84, 4'b1010);
    endtask

    // Code byte at pc, which the DUT must also fetch from pc
    task automatic storeFetchByte(inout addrT pc, input byteT value);
        mem[pc[7:0]] = value;
        expAddrs.push_back(pc);
        pc = pc + 16'd1;
    endtask

    task automatic runSection(input int first, input int last, input byteT haltSpec,
                              input string label);
        addrT pc;
        int   r;
        int   reqBase;
        int   violBase;
        int   errBefore;
        int   seen;
        pc = resetPc;
        @(negedge Sysclk);
        resetbar = 1'b0;
        expAddrs.delete();
        for (r = 0; r < 256; r++)
            mem[8'(r)] = 8'(r) ^ 8'h96;
        for (r = first; r <= last; r++)
        begin
            storeFetchByte(pc, rowSpec[r]);
            if (rowKind[r] != unaryInstr)
            begin
                storeFetchByte(pc, rowOs[r][15:8]);
                storeFetchByte(pc, rowOs[r][7:0]);
            end
            if (rowKind[r] == dirInstr)
            begin
                mem[rowOs[r][7:0]] = rowData[r];
                expAddrs.push_back(rowOs[r]);    // Operand read follows the spec fetch
            end
        end
        storeFetchByte(pc, haltSpec);

        errBefore = errorCount;
        repeat (5)
        begin
            @(negedge Sysclk);
            compareValue({label, " reset"}, "retire.valid", 16'd0, 16'(retire.valid));
            compareValue({label, " reset"}, "halted", 16'd0, 16'(cpuHalted));
            compareValue({label, " reset"}, "memReq.req", 16'd0, 16'(memReq.req));
        end
        finishTest({label, " reset"}, errBefore);

        reqBase  = reqAddrs.size();
        violBase = violations;
        resetbar = 1'b1;
        for (r = first; r <= last; r++)
        begin
            errBefore = errorCount;
            @(negedge Sysclk);
            while (!retire.valid)
                @(negedge Sysclk);
            compareValue(rowName[r], "dest", 16'(rowDest[r]), 16'(retire.dest));
            compareValue(rowName[r], "value", 16'(rowValue[r]), 16'(retire.value));
            compareValue(rowName[r], "flags", 16'(rowFlags[r]), 16'(retire.flags));
            finishTest(rowName[r], errBefore);
        end

        errBefore = errorCount;
        while (!cpuHalted)
        begin
            @(negedge Sysclk);
            if (retire.valid)
            begin
                $display("Section %s retired more instructions than its table rows", label);
                errorCount++;
            end
        end
        repeat (20)
        begin
            @(negedge Sysclk);
            if (retire.valid || memReq.req || !cpuHalted)
            begin
                $display("Section %s showed a request or retire after halting", label);
                errorCount++;
            end
        end
        finishTest({label, " halt"}, errBefore);

        errBefore = errorCount;
        seen = reqAddrs.size() - reqBase;
        compareValue({label, " fetch order"}, "requests", 16'(expAddrs.size()), 16'(seen));
        for (r = 0; r < expAddrs.size() && r < seen; r++)
            compareValue({label, " fetch order"}, "address", expAddrs[r], reqAddrs[reqBase + r]);
        finishTest({label, " fetch order"}, errBefore);

        errBefore = errorCount;
        compareValue({label, " handshake"}, "violations", 16'd0, 16'(violations - violBase));
        finishTest({label, " handshake"}, errBefore);
    endtask

    // Memory side of the req/ack port plus protocol monitor
    always @(negedge Sysclk)
    begin
        if (retire.valid)
            retireCount++;    // Every retire pulse, including any after halt
        if (memReq.req && !prevReq)
        begin
            reqAddrs.push_back(memReq.addr);
            if (memAck)
                violations++;    // New req before ack fell
            rngState   = xorshift(rngState);
            waitCycles = rngState[1:0];
        end
        if (memReq.req && prevReq && memReq.addr != prevAddr)
            violations++;
        prevReq  = memReq.req;
        prevAddr = memReq.addr;

        if (memReq.req && !memAck)
        begin
            if (waitCycles == 2'd0)
            begin
                memData = mem[memReq.addr[7:0]];
                memAck  = 1'b1;
            end
            else
                waitCycles = waitCycles - 2'd1;
        end
        else if (!memReq.req && memAck)
            memAck = 1'b0;    // Release phase
    end

    always @(posedge Sysclk)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        buildTable();
        runSection(0, 26, opStop, "stop");
        runSection(27, numRows - 1, 8'h62, "mode 2");
        compareValue("retire total", "count", 16'(numRows), 16'(retireCount));
        $display("Summary: %0d tests, %0d failing, %0d mismatches",
                 testCount, failCount, errorCount);
        if (errorCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
